// File: list.f
common/snake_pkg.sv
verilog/turn_input.sv
verilog/game_fsm.sv
snake/snake_body.sv
fruit/fruit_lfsr.sv
fruit/fruit_place.sv
verilog/snake_game.sv
verif/tb_snake_game.sv

// File: run.sh
#!/bin/sh
# Build the snake game testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snake_game -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_snake_game)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// File: verif/tb_snake_game.sv
////////////////////
// Self-checking testbench for the snake game core
// Plays scripted and random moves against a reference model of the snake
////////////////////
`timescale 1ns/1ps

module tb_snake_game import snake_pkg::*; ();

    localparam int body_slots      = 62;   // Segments behind the head
    localparam int moves_planned   = 153;  // 1 + 30 random + 1 + 5 collision + 116 to the wall
    localparam int cycles_per_move = 160;  // Tick spacing
    localparam int timeout_limit   = moves_planned * cycles_per_move * 3 / 2;

    logic        clock_25;
    logic        reset;
    logic        right_button;
    logic        left_button;
    logic        game_tik;
    snake_view_t view;
    cell_t       fruit;
    score_t      score;
    logic        playing;
    logic        game_over;

    // Reference model of the snake
    heading_t m_heading;
    cell_t    m_head;
    cell_t    m_body[body_slots];  // Index 0 is next to the head
    int       m_len;
    int       m_score;
    bit       m_started;           // First press seen
    bit       m_over;

    bit    check_req;
    bit    fruit_exact;  // Fruit must sit on its start cell
    string test_name;
    int    check_errors = 0;
    int    errors_at_start;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;

    snake_game dut (
        .clock_25     (clock_25),
        .reset        (reset),
        .right_button (right_button),
        .left_button  (left_button),
        .game_tik     (game_tik),
        .view         (view),
        .fruit        (fruit),
        .score        (score),
        .playing      (playing),
        .game_over    (game_over)
    );

    initial begin
        clock_25 = 1'b0;
        forever #20 clock_25 = ~clock_25;  // 25 MHz
    end

    // Turn codes: 0 none, 1 right, 2 left, 3 both
    function automatic heading_t rotate(heading_t h, int turn);
        if (turn == 1) begin
            case (h)
                head_up:    return head_right;
                head_right: return head_down;
                head_down:  return head_left;
                default:    return head_up;
            endcase
        end else if (turn == 2) begin
            case (h)
                head_up:    return head_left;
                head_left:  return head_down;
                head_down:  return head_right;
                default:    return head_up;
            endcase
        end
        return h;  // Both buttons cancel
    endfunction

    // One cell on, blocked at the edge
    function automatic cell_t step_cell(cell_t c, heading_t h);
        cell_t n;
        n = c;
        case (h)
            head_up:    if (c.y > 0) n.y = c.y - 7'd1;
            head_right: if (int'(c.x) < h_cells - 1) n.x = c.x + 7'd1;
            head_down:  if (int'(c.y) < v_cells - 1) n.y = c.y + 7'd1;
            default:    if (c.x > 0) n.x = c.x - 7'd1;
        endcase
        return n;
    endfunction

    function automatic bit points_out(cell_t c, heading_t h);
        return (h == head_left && c.x == 0) || (h == head_up && c.y == 0) ||
               (h == head_right && int'(c.x) == h_cells - 1) ||
               (h == head_down && int'(c.y) == v_cells - 1);
    endfunction

    // Would this turn end the game on the next move
    function automatic bit move_crashes(int turn);
        heading_t nh;
        cell_t    nc;
        bit       hit;
        nh  = rotate(m_heading, turn);
        nc  = step_cell(m_head, nh);
        hit = points_out(nc, nh);
        if (m_len > 1 && nc == m_head) hit = 1'b1;  // Old head becomes segment 0
        for (int i = 0; i < m_len - 2; i++) begin
            if (m_body[i] == nc) hit = 1'b1;
        end
        return hit;
    endfunction

    // Reference: one game tick with the latched turn and the fruit seen before it
    function automatic void step_model(int turn, cell_t fruit_seen);
        heading_t nh;
        cell_t    nc;
        bit       hit;
        if (m_over || !m_started) return;  // Tick ignored
        nh  = rotate(m_heading, turn);
        nc  = step_cell(m_head, nh);
        hit = move_crashes(turn);
        for (int i = body_slots - 1; i > 0; i--) begin
            m_body[i] = m_body[i-1];
        end
        m_body[0] = m_head;
        m_head    = nc;
        m_heading = nh;
        if (hit) begin
            m_over = 1'b1;
        end else if (nc == fruit_seen) begin
            if (m_len < 63) m_len++;
            m_score = (m_score == 99) ? 0 : m_score + 1;  // Wraps at 99
        end
    endfunction

    function automatic void restart_model();
        m_heading = head_right;
        m_head    = '{x: 7'd8, y: 7'd40};
        m_len     = 6;
        m_score   = 0;
        m_started = 1'b0;
        m_over    = 1'b0;
        for (int i = 0; i < body_slots; i++) begin
            if (i < 5) m_body[i] = '{x: coord_t'(7 - i), y: 7'd40};  // Trailing left of the head
            else m_body[i] = '{x: 7'd127, y: 7'd127};
        end
    endfunction

    // Inside the playfield minus the last row and column, clear of the snake
    function automatic bit fruit_allowed(cell_t f);
        bit ok;
        ok = int'(f.x) < h_cells - 1 && int'(f.y) < v_cells - 1 && f != m_head;
        for (int i = 0; i < m_len - 1; i++) begin
            if (m_body[i] == f) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic next_cycles(int n);
        repeat (n) @(posedge clock_25);
        #2;  // Drive just after the edge
    endtask

    task automatic press_buttons(bit r, bit l);
        right_button = r;
        left_button  = l;
        next_cycles(3);
        right_button = 1'b0;
        left_button  = 1'b0;
        next_cycles(2);  // Press pulse has reached the latch
    endtask

    task automatic compare_now();
        check_req = 1'b1;
        next_cycles(1);
        check_req = 1'b0;
    endtask

    task automatic play_move(int turn);
        cell_t seen;
        int    t;
        t = m_over ? 0 : turn;  // A press in collision would restart
        if (t != 0) press_buttons(t == 1 || t == 3, t == 2 || t == 3);
        else next_cycles(5);
        seen     = fruit;
        game_tik = 1'b1;
        next_cycles(1);
        game_tik = 1'b0;
        step_model(t, seen);
        next_cycles(149);  // Longest fruit retry is well inside this
        compare_now();
        next_cycles(3);
    endtask

    task automatic start_test(string name);
        test_name       = name;
        errors_at_start = check_errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (check_errors == errors_at_start) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, check_errors - errors_at_start);
        end
    endtask

    // Compares DUT outputs with the model on request
    always @(posedge clock_25) begin
        if (check_req) begin
            assert (view.head == m_head) else begin
                $display("Fail %s head expected (%0d,%0d) actual (%0d,%0d)", test_name,
                         m_head.x, m_head.y, view.head.x, view.head.y);
                check_errors++;
            end
            assert (view.heading == m_heading) else begin
                $display("Fail %s heading expected %0d actual %0d", test_name,
                         m_heading, view.heading);
                check_errors++;
            end
            assert (int'(view.length) == m_len) else begin
                $display("Fail %s length expected %0d actual %0d", test_name, m_len, view.length);
                check_errors++;
            end
            assert (int'(score) == m_score) else begin
                $display("Fail %s score expected %0d actual %0d", test_name, m_score, score);
                check_errors++;
            end
            assert (playing == (m_started && !m_over)) else begin
                $display("Fail %s playing expected %0d actual %0d", test_name,
                         m_started && !m_over, playing);
                check_errors++;
            end
            assert (game_over == m_over) else begin
                $display("Fail %s game_over expected %0d actual %0d", test_name, m_over, game_over);
                check_errors++;
            end
            if (fruit_exact) begin
                assert (fruit.x == 7'd9 && fruit.y == 7'd40) else begin
                    $display("Fail %s fruit expected (9,40) actual (%0d,%0d)", test_name,
                             fruit.x, fruit.y);
                    check_errors++;
                end
            end else if (!m_over) begin
                assert (fruit_allowed(fruit)) else begin
                    $display("Error in %s: fruit at (%0d,%0d) is off the grid or on the snake",
                             test_name, fruit.x, fruit.y);
                    check_errors++;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clock_25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int  first_draw;
        int  r;
        int  pick;
        bit  found;
        int  guard;
        first_draw   = $urandom(82);  // Seeds the generator
        reset        = 1'b0;
        right_button = 1'b0;
        left_button  = 1'b0;
        game_tik     = 1'b0;
        check_req    = 1'b0;
        fruit_exact  = 1'b0;
        restart_model();
        repeat (3) @(posedge clock_25);
        #2 reset = 1'b1;
        next_cycles(4);

        start_test("after_reset");
        fruit_exact = 1'b1;
        compare_now();
        fruit_exact = 1'b0;
        finish_test();

        start_test("first_move");
        press_buttons(1'b1, 1'b0);  // Only starts the game
        m_started = 1'b1;
        play_move(0);               // Lands on the start fruit
        finish_test();

        start_test("random_steering");
        for (int n = 0; n < 30; n++) begin
            r     = $urandom_range(3, 0);
            pick  = r;
            found = 1'b0;
            for (int k = 0; k < 4; k++) begin
                if (!found && !move_crashes((r + k) % 4)) begin
                    pick  = (r + k) % 4;
                    found = 1'b1;
                end
            end
            play_move(pick);
        end
        finish_test();

        start_test("both_buttons");
        play_move(3);
        finish_test();

        start_test("self_collision");
        play_move(1);
        play_move(1);
        play_move(1);  // Back onto the cell behind the old head
        play_move(0);
        play_move(0);  // Ticks after game over change nothing
        finish_test();

        start_test("restart");
        press_buttons(1'b1, 1'b0);
        restart_model();
        next_cycles(2);
        fruit_exact = 1'b1;
        compare_now();
        fruit_exact = 1'b0;
        finish_test();

        start_test("wall_collision");
        press_buttons(1'b0, 1'b1);
        m_started = 1'b1;
        guard     = 0;
        while (!m_over && guard < 130) begin
            play_move(0);  // Straight right along row 40
            guard++;
        end
        play_move(0);
        finish_test();

        $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/snake_game.sv
////////////////////
// Top of the snake game core
// Sets capacity and seeds, connects buttons, FSM, body and fruit
////////////////////
`timescale 1ns/1ps

module snake_game import snake_pkg::*; #(
    parameter int     max_len = 63,
    parameter coord_t seed_x  = 7'b0011100,
    parameter coord_t seed_y  = 7'b0110000
) (
    input  logic        clock_25,
    input  logic        reset,
    input  logic        right_button,
    input  logic        left_button,
    input  logic        game_tik,      // One cycle pulse per game step
    output snake_view_t view,
    output cell_t       fruit,
    output score_t      score,
    output logic        playing,
    output logic        game_over
);

    logic                press;
    logic                turn_cw;
    logic                turn_ccw;
    game_state_t         state;
    logic                sync_clear;
    logic                move_en;
    logic                grow_en;
    logic                place_en;
    logic                crash;
    logic                eaten;
    logic                misplaced;
    cell_t [max_len-2:0] body_bus;
    len_t                body_count;

    turn_input u_turn_input (
        .clock_25     (clock_25),
        .reset        (reset),
        .right_button (right_button),
        .left_button  (left_button),
        .idle         (state == st_idle),  // First press only starts the game
        .consume      (move_en),
        .clear        (sync_clear),
        .press        (press),
        .turn_cw      (turn_cw),
        .turn_ccw     (turn_ccw)
    );

    game_fsm u_game_fsm (
        .clock_25   (clock_25),
        .reset      (reset),
        .press      (press),
        .game_tik   (game_tik),
        .crash      (crash),
        .eaten      (eaten),
        .misplaced  (misplaced),
        .state      (state),
        .sync_clear (sync_clear),
        .move_en    (move_en),
        .grow_en    (grow_en),
        .place_en   (place_en),
        .playing    (playing),
        .game_over  (game_over)
    );

    snake_body #(.max_len(max_len)) u_snake_body (
        .clock_25   (clock_25),
        .reset      (reset),
        .sync_clear (sync_clear),
        .move_en    (move_en),
        .grow_en    (grow_en),
        .turn_cw    (turn_cw),
        .turn_ccw   (turn_ccw),
        .view       (view),
        .body_bus   (body_bus),
        .body_count (body_count),
        .crash      (crash)
    );

    fruit_place #(
        .max_len (max_len),
        .seed_x  (seed_x),
        .seed_y  (seed_y)
    ) u_fruit_place (
        .clock_25   (clock_25),
        .reset      (reset),
        .sync_clear (sync_clear),
        .grow_en    (grow_en),
        .place_en   (place_en),
        .view       (view),
        .body_bus   (body_bus),
        .body_count (body_count),
        .fruit      (fruit),
        .eaten      (eaten),
        .misplaced  (misplaced),
        .score      (score)
    );

endmodule

// File: fruit/fruit_place.sv
////////////////////
// Fruit position and score
// New fruit comes from two LFSRs, retried while it sits on the snake or off grid
////////////////////
`timescale 1ns/1ps

module fruit_place import snake_pkg::*; #(
    parameter int     max_len = 63,
    parameter coord_t seed_x  = 7'b0011100,
    parameter coord_t seed_y  = 7'b0110000
) (
    input  logic                clock_25,
    input  logic                reset,
    input  logic                sync_clear,
    input  logic                grow_en,
    input  logic                place_en,
    input  snake_view_t         view,
    input  cell_t [max_len-2:0] body_bus,
    input  len_t                body_count,
    output cell_t               fruit,
    output logic                eaten,
    output logic                misplaced,
    output score_t              score
);

    coord_t rnd_x;
    coord_t rnd_y;
    logic   on_body;
    logic   off_grid;

    fruit_lfsr #(.seed(seed_x)) u_lfsr_x (
        .clock_25 (clock_25),
        .reset    (reset),
        .value    (rnd_x)
    );

    fruit_lfsr #(.seed(seed_y)) u_lfsr_y (
        .clock_25 (clock_25),
        .reset    (reset),
        .value    (rnd_y)
    );

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit <= start_fruit;
            score <= '0;
        end else if (sync_clear) begin
            fruit <= start_fruit;
            score <= '0;
        end else if (grow_en) begin
            fruit <= '{x: rnd_x, y: rnd_y};
            score <= (score == score_wrap) ? '0 : score + 1'b1;  // Wraps 99 to 0
        end else if (place_en && misplaced) begin
            fruit <= '{x: rnd_x, y: rnd_y};  // Fresh pair every cycle
        end
    end

    // Last column and row are kept clear
    assign off_grid = (fruit.x >= coord_t'(h_cells - 1)) || (fruit.y >= coord_t'(v_cells - 1));

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < max_len - 1; i++) begin
            if (i < body_count && body_bus[i] == fruit) begin
                on_body = 1'b1;
            end
        end
    end

    assign eaten     = (fruit == view.head);
    assign misplaced = off_grid | on_body | eaten;

endmodule

// File: fruit/fruit_lfsr.sv
////////////////////
// Free running 7 bit LFSR for fruit coordinates
// Polynomial x^7 + x^6 + 1, period 127, seed must be nonzero
////////////////////
`timescale 1ns/1ps

module fruit_lfsr import snake_pkg::*; #(
    parameter coord_t seed = 7'b0000001
) (
    input  logic   clock_25,
    input  logic   reset,
    output coord_t value
);

    logic feedback;

    assign feedback = value[6] ^ value[5];  // Taps 7 and 6

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            value <= seed;
        end else begin
            value <= {value[5:0], feedback};  // Never reaches zero from a nonzero seed
        end
    end

endmodule

// File: snake/snake_body.sv
////////////////////
// Snake head, heading, body segments and length
// Steps one cell per move_en, grows on grow_en, flags wall and self hits
////////////////////
`timescale 1ns/1ps

module snake_body import snake_pkg::*; #(
    parameter int max_len = 63  // Head plus max_len-1 segments
) (
    input  logic                      clock_25,
    input  logic                      reset,
    input  logic                      sync_clear,
    input  logic                      move_en,
    input  logic                      grow_en,
    input  logic                      turn_cw,
    input  logic                      turn_ccw,
    output snake_view_t               view,
    output cell_t [max_len-2:0]       body_bus,   // Segment 0 is next to the head
    output len_t                      body_count, // Active segments
    output logic                      crash
);

    heading_t heading;
    heading_t next_heading;
    cell_t    head;
    cell_t    next_head;
    len_t     length;
    logic     wall_hit;
    logic     self_hit;

    // Rotate first, then step in the new direction
    always_comb begin
        next_heading = heading;
        if (turn_cw) begin
            next_heading = heading_t'(heading + 2'd1);
        end else if (turn_ccw) begin
            next_heading = heading_t'(heading - 2'd1);
        end
        next_head = head;
        unique case (next_heading)
            head_up:    if (head.y != '0) next_head.y = head.y - 1'b1;
            head_right: if (head.x != coord_t'(h_cells - 1)) next_head.x = head.x + 1'b1;
            head_down:  if (head.y != coord_t'(v_cells - 1)) next_head.y = head.y + 1'b1;
            head_left:  if (head.x != '0) next_head.x = head.x - 1'b1;
            default:    next_head = head;
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            heading <= head_right;
            head    <= start_head;
            length  <= start_length;
        end else if (sync_clear) begin
            heading <= head_right;
            head    <= start_head;
            length  <= start_length;
        end else if (move_en) begin
            heading <= next_heading;
            head    <= next_head;  // Stays put at the wall, crash catches it
        end else if (grow_en && length != len_t'(max_len)) begin
            length <= length + 1'b1;  // Saturates at capacity
        end
    end

    // Whole chain shifts, so the slot past the tail keeps the vacated cell
    // and a grow picks it up as the new tail
    always_ff @(posedge clock_25) begin
        if (sync_clear) begin
            for (int i = 0; i < max_len - 1; i++) begin
                if (i < start_length - 1) begin
                    body_bus[i] <= '{x: coord_t'(start_head.x - i - 1), y: start_head.y};
                end else begin
                    body_bus[i] <= '{x: '1, y: '1};  // Off grid
                end
            end
        end else if (move_en) begin
            body_bus[0] <= head;
            for (int i = 1; i < max_len - 1; i++) begin
                body_bus[i] <= body_bus[i-1];
            end
        end
    end

    assign body_count = length - 1'b1;

    // Heading points out of the grid from an edge cell
    assign wall_hit = (head.x == '0 && heading == head_left) ||
                      (head.x == coord_t'(h_cells - 1) && heading == head_right) ||
                      (head.y == '0 && heading == head_up) ||
                      (head.y == coord_t'(v_cells - 1) && heading == head_down);

    // Head on any active segment
    always_comb begin
        self_hit = 1'b0;
        for (int i = 0; i < max_len - 1; i++) begin
            if (i < body_count && body_bus[i] == head) begin
                self_hit = 1'b1;
            end
        end
    end

    assign crash = wall_hit | self_hit;

    assign view = '{head: head, length: length, heading: heading};

    head_on_grid: assert property (@(posedge clock_25) disable iff (!reset)
        head.x < h_cells && head.y < v_cells);

endmodule

// File: verilog/game_fsm.sv
////////////////////
// Game state machine
// Moore outputs are the strobes that step the snake and place the fruit
////////////////////
`timescale 1ns/1ps

module game_fsm import snake_pkg::*; (
    input  logic        clock_25,
    input  logic        reset,
    input  logic        press,
    input  logic        game_tik,
    input  logic        crash,
    input  logic        eaten,
    input  logic        misplaced,
    output game_state_t state,
    output logic        sync_clear,
    output logic        move_en,
    output logic        grow_en,
    output logic        place_en,
    output logic        playing,
    output logic        game_over
);

    game_state_t next_state;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state <= st_reset_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;  // Hold by default
        unique case (state)
            st_reset_idle: next_state = st_idle;
            st_idle:       if (press) next_state = st_wait;
            st_wait:       if (game_tik) next_state = st_moving;  // Ticks elsewhere are lost
            st_moving:     next_state = st_move_done;
            st_move_done: begin
                // Head already updated here
                if (crash) begin
                    next_state = st_collision;
                end else if (eaten) begin
                    next_state = st_eaten;
                end else begin
                    next_state = st_wait;
                end
            end
            st_eaten:        next_state = st_fruit_update;
            st_fruit_update: if (!misplaced) next_state = st_wait;  // Retry until clean
            st_collision:    if (press) next_state = st_reset_idle;
            default:         next_state = st_reset_idle;
        endcase
    end

    // Decoded from the state alone
    always_comb begin
        sync_clear = 1'b0;
        move_en    = 1'b0;
        grow_en    = 1'b0;
        place_en   = 1'b0;
        playing    = 1'b0;
        game_over  = 1'b0;
        unique case (state)
            st_reset_idle:   sync_clear = 1'b1;
            st_idle:         ;
            st_wait:         playing = 1'b1;
            st_moving: begin
                move_en = 1'b1;
                playing = 1'b1;
            end
            st_move_done:    playing = 1'b1;
            st_eaten: begin
                grow_en = 1'b1;
                playing = 1'b1;
            end
            st_fruit_update: begin
                place_en = 1'b1;
                playing  = 1'b1;
            end
            st_collision:    game_over = 1'b1;
            default:         sync_clear = 1'b1;
        endcase
    end

    // Snake body and fruit rely on these never overlapping
    strobes_exclusive: assert property (@(posedge clock_25) disable iff (!reset)
        $onehot0({move_en, grow_en, place_en}));

endmodule

// File: verilog/turn_input.sv
////////////////////
// Button front end of the game
// Synchronises both buttons, finds rising edges, holds one turn per move
////////////////////
`timescale 1ns/1ps

module turn_input (
    input  logic clock_25,
    input  logic reset,
    input  logic right_button,
    input  logic left_button,
    input  logic idle,        // FSM waits for the first press
    input  logic consume,     // Move done with the latched turn
    input  logic clear,       // Restart of the game
    output logic press,
    output logic turn_cw,
    output logic turn_ccw
);

    // Bits 0 and 1 synchronise, bit 2 keeps the previous level for the edge
    logic [2:0] right_sync;
    logic [2:0] left_sync;
    logic       right_rise;  // Registered edge pulses
    logic       left_rise;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_sync <= '0;
            left_sync  <= '0;
            right_rise <= 1'b0;
            left_rise  <= 1'b0;
        end else begin
            right_sync <= {right_sync[1:0], right_button};
            left_sync  <= {left_sync[1:0], left_button};
            right_rise <= right_sync[1] & ~right_sync[2];  // Third edge after the button
            left_rise  <= left_sync[1] & ~left_sync[2];
        end
    end

    assign press = right_rise | left_rise;

    // Turn latch, the last press before the move wins
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (clear) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (press && !idle) begin
            turn_cw  <= right_rise & ~left_rise;  // Both at once gives no turn
            turn_ccw <= left_rise & ~right_rise;
        end else if (consume) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end
    end

    // Body would otherwise see two turns in one move
    turn_exclusive: assert property (@(posedge clock_25) disable iff (!reset)
        !(turn_cw && turn_ccw));

endmodule

// File: common/snake_pkg.sv
////////////////////
// Shared types and constants of the snake game core
// Imported by every block that deals with cells, lengths or states
////////////////////

package snake_pkg;

    // Playfield size in cells
    parameter int h_cells = 124;
    parameter int v_cells = 81;

    typedef logic [6:0] coord_t;  // One grid coordinate
    typedef logic [5:0] len_t;    // Snake length, head included
    typedef logic [6:0] score_t;  // Score, 0 to 99

    // Clockwise order, so a right turn is +1 and a left turn is -1
    typedef enum logic [1:0] {
        head_up,
        head_right,
        head_down,
        head_left
    } heading_t;

    typedef enum logic [2:0] {
        st_reset_idle,
        st_idle,          // Waiting for the first press
        st_wait,          // Waiting for a game tick
        st_moving,
        st_move_done,
        st_eaten,
        st_fruit_update,
        st_collision
    } game_state_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    // What the outside sees of the snake
    typedef struct packed {
        cell_t    head;
        len_t     length;
        heading_t heading;
    } snake_view_t;

    // Start of game
    parameter cell_t  start_head   = '{x: 7'd8, y: 7'd40};
    parameter cell_t  start_fruit  = '{x: 7'd9, y: 7'd40};
    parameter len_t   start_length = 6'd6;
    parameter score_t score_wrap   = 7'd99;

endpackage
